// ==== bench/sdio_cmd_stim.txt ====
# act opc arg rsp dly dir rnd payload busy exp_rsp exp_status, all hex
# act 0 normal, 1 second strobe, 2 clear; dly FF card silent; rnd 1 lfsr payload
0 00 00000000 0 00 0 0 0 0 0 00
0 08 000001AA 1 03 0 0 08000001AA 0 08000001AA 00
0 29 40FF8000 2 05 0 0 3F00FF8000 0 3F00FF8000 00
0 02 00000000 3 02 0 1 0 0 0 00
0 07 12340000 4 04 0 0 0912340000 14 0912340000 00
0 0C 00000000 4 01 0 1 0 12C 0 04
0 11 00000200 1 FF 0 0 0 0 0 01
0 0D 00010000 1 03 1 0 0 0 0 02
1 00 00000000 0 00 0 0 0 0 0 08
2 11 00000400 1 00 0 0 0 0 0 00
0 10 00000200 2 06 0 1 0 0 0 00

// ==== vlog.f ====
source/sdio_pkg.sv
source/sdio_crc7.sv
source/sdio_txrx_cmd.sv
source/sdio_cmd_regs.sv
source/sdio_cmd_top.sv
bench/sdio_cmd_sva.sv
bench/sdio_cmd_checker.sv
bench/tb_sdio_cmd.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_sdio_cmd -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"

// ==== bench/tb_sdio_cmd.sv ====
`timescale 1ns/1ns
// Testbench for the SD host command path
// runs the tests of the stim file and plays the card on the CMD line

module tb_sdio_cmd import sdio_pkg::*; ();

    localparam int MAX_TESTS = 32;

    logic         clk_i       = 1'b0;
    logic         rstn_i      = 1'b0;
    logic         cmd_wr_i    = 1'b0;
    cmd_desc_t    cmd_desc_i  = '0;
    logic         clr_i       = 1'b0;
    logic         sd_busy_i   = 1'b0;
    logic         sdcmd_i     = 1'b1;
    logic         done_o;
    cmd_result_t  result_o;
    logic         sdclk_en_o;
    logic         sdcmd_o;
    logic         sdcmd_oen_o;

    logic [3:0]   t_action[MAX_TESTS];
    logic [5:0]   t_opcode[MAX_TESTS];
    logic [31:0]  t_arg[MAX_TESTS];
    logic [2:0]   t_rsp[MAX_TESTS];
    logic [7:0]   t_delay[MAX_TESTS];
    logic         t_dir[MAX_TESTS];
    logic         t_rnd[MAX_TESTS];
    logic [135:0] t_payload[MAX_TESTS];
    logic [15:0]  t_busy[MAX_TESTS];
    logic [127:0] t_exp_rsp[MAX_TESTS];
    logic [5:0]   t_exp_status[MAX_TESTS];
    int           n_tests = 0;
    int           n_ends  = 0;
    int           err_cnt;

    // card model state
    logic         card_armed   = 1'b0;
    logic         card_active  = 1'b0;
    logic         card_dir     = 1'b0;
    logic         card_rnd     = 1'b0;
    int           card_n       = 38;
    int           card_delay   = 0;
    int           card_busy    = 0;
    rsp_type_e    card_type    = RSP_NONE;
    logic [135:0] card_payload = '0;
    logic [135:0] card_sent    = '0;
    logic [15:0]  lfsr_q       = 16'd46802;

    cmd_desc_t    exp_desc     = '0;
    logic [127:0] exp_rsp      = '0;
    status_t      exp_status   = '0;
    logic         use_file_rsp = 1'b0;

    always #10 clk_i = ~clk_i;

    sdio_cmd_top sdio_cmd_top_inst
    (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .cmd_wr_i    (cmd_wr_i),
        .cmd_desc_i  (cmd_desc_i),
        .clr_i       (clr_i),
        .sd_busy_i   (sd_busy_i),
        .sdcmd_i     (sdcmd_i),
        .done_o      (done_o),
        .result_o    (result_o),
        .sdclk_en_o  (sdclk_en_o),
        .sdcmd_o     (sdcmd_o),
        .sdcmd_oen_o (sdcmd_oen_o)
    );

    sdio_cmd_checker checker_inst
    (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .done_i         (done_o),
        .result_i       (result_o),
        .sdcmd_i        (sdcmd_o),
        .sdcmd_oen_i    (sdcmd_oen_o),
        .sdclk_en_i     (sdclk_en_o),
        .exp_desc_i     (exp_desc),
        .exp_rsp_i      (exp_rsp),
        .exp_status_i   (exp_status),
        .use_file_rsp_i (use_file_rsp),
        .card_sent_i    (card_sent),
        .err_cnt_o      (err_cnt)
    );

    bind sdio_txrx_cmd sdio_cmd_sva sdio_cmd_sva_inst
    (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .state_i     (state_q),
        .cmd_start_i (cmd_start_i),
        .sdcmd_oen_i (sdcmd_oen_o),
        .sdclk_en_i  (sdclk_en_o),
        .eot_i       (eot_o)
    );

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic read_tests();
        int           fd;
        int           code;
        string        line;
        logic [3:0]   act;
        logic [5:0]   opc;
        logic [31:0]  arg;
        logic [2:0]   rsp;
        logic [7:0]   dly;
        logic         dir;
        logic         rnd;
        logic [135:0] pay;
        logic [15:0]  bsy;
        logic [127:0] er;
        logic [5:0]   es;
        fd = $fopen("bench/sdio_cmd_stim.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the stim file bench/sdio_cmd_stim.txt");
            return;
        end
        while (!$feof(fd) && n_tests < MAX_TESTS)
        begin
            code = $fgets(line, fd);
            if (code > 1 && line[0] != "#")
            begin
                code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                               act, opc, arg, rsp, dly, dir, rnd, pay, bsy, er, es);
                if (code == 11)
                begin
                    t_action[n_tests]     = act;
                    t_opcode[n_tests]     = opc;
                    t_arg[n_tests]        = arg;
                    t_rsp[n_tests]        = rsp;
                    t_delay[n_tests]      = dly;
                    t_dir[n_tests]        = dir;
                    t_rnd[n_tests]        = rnd;
                    t_payload[n_tests]    = pay;
                    t_busy[n_tests]       = bsy;
                    t_exp_rsp[n_tests]    = er;
                    t_exp_status[n_tests] = es;
                    n_tests++;
                end
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////
    // card model on the CMD line
    ////////////////////////////////////////
    always
    begin
        @(posedge sdcmd_oen_o);
        if (card_armed)
        begin
            card_armed  = 1'b0;
            card_active = 1'b1;
            repeat (card_delay) @(posedge clk_i);
            @(posedge clk_i);
            #2;
            sdcmd_i = 1'b0;  // start bit
            if (card_type == RSP_48_BSY)
                sd_busy_i = 1'b1;
            @(posedge clk_i);
            #2;
            sdcmd_i = card_dir;
            if (!card_dir)
            begin
                for (int i = card_n - 1; i >= 0; i--)
                begin
                    @(posedge clk_i);
                    #2;
                    lfsr_q    = lfsr_step(lfsr_q);
                    sdcmd_i   = card_rnd ? lfsr_q[0] : card_payload[i];
                    card_sent = {card_sent[134:0], sdcmd_i};
                end
                if (card_type == RSP_48_CRC || card_type == RSP_48_BSY)
                begin
                    repeat (8)
                    begin
                        @(posedge clk_i);
                        #2;
                        sdcmd_i = 1'b1;  // crc and end bit, not checked
                    end
                end
                repeat (card_busy) @(posedge clk_i);
                #2;
                sd_busy_i = 1'b0;
            end
            @(posedge clk_i);
            #2;
            sdcmd_i     = 1'b1;
            sd_busy_i   = 1'b0;
            card_active = 1'b0;
        end
    end

    task automatic run_test(input int t);
        exp_desc     = {t_opcode[t], t_arg[t], rsp_type_e'(t_rsp[t])};
        exp_rsp      = t_exp_rsp[t];
        exp_status   = t_exp_status[t];
        use_file_rsp = !t_rnd[t];
        card_sent    = '0;
        card_type    = rsp_type_e'(t_rsp[t]);
        card_n       = (card_type == RSP_136) ? RSP136_BITS : RSP48_BITS;
        card_delay   = int'(t_delay[t]);
        card_busy    = int'(t_busy[t]);
        card_dir     = t_dir[t];
        card_rnd     = t_rnd[t];
        card_payload = t_payload[t];
        card_armed   = (t_action[t] != 4'd2) && (t_delay[t] != 8'hFF) && (card_type != RSP_NONE);
        @(posedge clk_i);
        #2;
        cmd_desc_i = exp_desc;
        cmd_wr_i   = 1'b1;
        @(posedge clk_i);
        #2;
        cmd_wr_i = 1'b0;
        if (t_action[t] == 4'd1)
        begin
            repeat (10) @(posedge clk_i);
            #2;
            cmd_wr_i = 1'b1;  // must be refused
            @(posedge clk_i);
            #2;
            cmd_wr_i = 1'b0;
        end
        if (t_action[t] == 4'd2)
        begin
            repeat (20) @(posedge clk_i);
            #2;
            clr_i = 1'b1;
            @(posedge clk_i);
            #2;
            clr_i = 1'b0;
            @(posedge clk_i);
            checker_inst.check_released();
            repeat (30) @(posedge clk_i);
        end
        else
        begin
            n_ends++;
            do
                @(negedge clk_i);
            while (!done_o);
            wait (!card_active);
            repeat (4) @(posedge clk_i);
        end
    endtask

    // watchdog sized from the number of tests
    initial
    begin
        wait (n_tests > 0);
        repeat (n_tests * 500) @(posedge clk_i);
        $display("watchdog expired, the tests did not finish in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial
    begin
        read_tests();
        repeat (5) @(posedge clk_i);
        #2;
        rstn_i = 1'b1;
        if (n_tests == 0)
            $display("no tests were read from the stim file");
        for (int t = 0; t < n_tests; t++)
            run_test(t);
        checker_inst.check_counts(n_ends, n_ends);
        $display("tests: %0d  errors: %0d", n_tests, err_cnt);
        if (err_cnt == 0 && n_tests > 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== bench/sdio_cmd_checker.sv ====
`timescale 1ns/1ns
// Command path checker
// decodes each sent frame, compares results at done and counts errors

module sdio_cmd_checker import sdio_pkg::*;
(
    input  logic         clk_i,
    input  logic         rstn_i,
    input  logic         done_i,
    input  cmd_result_t  result_i,
    input  logic         sdcmd_i,
    input  logic         sdcmd_oen_i,
    input  logic         sdclk_en_i,
    input  cmd_desc_t    exp_desc_i,
    input  logic [127:0] exp_rsp_i,
    input  status_t      exp_status_i,
    input  logic         use_file_rsp_i,
    input  logic [135:0] card_sent_i,
    output int           err_cnt_o
);

    int          err_cnt   = 0;
    int          done_cnt  = 0;
    int          frame_cnt = 0;
    int          bit_cnt   = 0;
    logic [47:0] frame     = '0;

    assign err_cnt_o = err_cnt;

    // x^7 + x^3 + 1, msb first, register starts at zero
    function automatic logic [6:0] crc7_of(input logic [39:0] bits);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--)
        begin
            fb  = bits[i] ^ crc[6];
            crc = {crc[5:0], 1'b0};
            if (fb)
                crc = crc ^ 7'h09;
        end
        return crc;
    endfunction

    task automatic check_frame(input logic [47:0] f);
        logic [6:0] exp_crc;
        exp_crc = crc7_of({2'b01, exp_desc_i.opcode, exp_desc_i.arg});
        if (f[47] !== 1'b0 || f[46] !== 1'b1 || f[0] !== 1'b1)
        begin
            $display("** Error at %0t: bad start, direction or stop bit in frame %h", $time, f);
            err_cnt++;
        end
        if (f[45:8] !== {exp_desc_i.opcode, exp_desc_i.arg})
        begin
            $display("** Error at %0t: frame payload %h, expected %h", $time, f[45:8],
                     {exp_desc_i.opcode, exp_desc_i.arg});
            err_cnt++;
        end
        if (f[7:1] !== exp_crc)
        begin
            $display("** Error at %0t: frame crc %h, expected %h", $time, f[7:1], exp_crc);
            err_cnt++;
        end
    endtask

    ////////////////////////////////////////
    // frame collection on rising edges
    ////////////////////////////////////////
    always @(posedge clk_i)
    begin
        if (rstn_i && !sdcmd_oen_i)
        begin
            if (sdclk_en_i !== 1'b1)
            begin
                $display("** Error at %0t: sd clock disabled while the frame is sent", $time);
                err_cnt++;
            end
            frame = {frame[46:0], sdcmd_i};
            bit_cnt++;
            if (bit_cnt == 48)
            begin
                frame_cnt++;
                check_frame(frame);
                bit_cnt = 0;
            end
        end
        else
        begin
            bit_cnt = 0;  // aborted or idle
        end
    end

    // results are stable on the falling edge
    always @(negedge clk_i)
    begin
        if (rstn_i && done_i)
        begin
            done_cnt++;
            if (sdclk_en_i !== 1'b0)
            begin
                $display("** Error at %0t: sd clock still enabled at done", $time);
                err_cnt++;
            end
            if (result_i.status !== exp_status_i)
            begin
                $display("** Error at %0t: status %h, expected %h", $time,
                         result_i.status, exp_status_i);
                err_cnt++;
            end
            if (result_i.rsp !== card_sent_i[127:0])
            begin
                $display("** Error at %0t: rsp %h, card sent %h", $time,
                         result_i.rsp, card_sent_i[127:0]);
                err_cnt++;
            end
            if (use_file_rsp_i && result_i.rsp !== exp_rsp_i)
            begin
                $display("** Error at %0t: rsp %h, expected %h", $time, result_i.rsp, exp_rsp_i);
                err_cnt++;
            end
        end
    end

    task automatic check_released();
        @(posedge clk_i);
        if (sdcmd_oen_i !== 1'b1 || sdcmd_i !== 1'b1)
        begin
            $display("** Error at %0t: CMD line not released after clear", $time);
            err_cnt++;
        end
    endtask

    task automatic check_counts(input int exp_done, input int exp_frames);
        if (done_cnt != exp_done || frame_cnt != exp_frames)
        begin
            $display("** Error at %0t: %0d done strobes and %0d frames, expected %0d and %0d",
                     $time, done_cnt, frame_cnt, exp_done, exp_frames);
            err_cnt++;
        end
    endtask

endmodule

// ==== bench/sdio_cmd_sva.sv ====
`timescale 1ns/1ns
// Engine assertions
// line release while receiving, clock enable in idle, eot pulse width

module sdio_cmd_sva import sdio_pkg::*;
(
    input logic       clk_i,
    input logic       rstn_i,
    input cmd_state_e state_i,
    input logic       cmd_start_i,
    input logic       sdcmd_oen_i,
    input logic       sdclk_en_i,
    input logic       eot_i
);

    // card owns the line once the stop bit is out
    rx_release_a : assert property (@(posedge clk_i) disable iff (!rstn_i)
        state_i inside {ST_RX_START, ST_RX_DIR, ST_RX_SHIFT, ST_RX_CRC, ST_WAIT_BUSY}
        |-> sdcmd_oen_i)
        else $error("CMD line driven in a receive state");

    // no start pulse, no sd clock in the next cycle
    idle_clk_a : assert property (@(posedge clk_i) disable iff (!rstn_i)
        (state_i == ST_IDLE) && !cmd_start_i |=> !sdclk_en_i)
        else $error("sd clock enabled while idle with no start pulse");

    eot_pulse_a : assert property (@(posedge clk_i) disable iff (!rstn_i)
        eot_i |=> !eot_i)
        else $error("eot longer than one cycle");

endmodule

// ==== source/sdio_cmd_top.sv ====
`timescale 1ns/1ns
// SD host command path top
// front end registers feeding the CMD line engine

module sdio_cmd_top import sdio_pkg::*;
(
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        cmd_wr_i,
    input  cmd_desc_t   cmd_desc_i,
    input  logic        clr_i,
    input  logic        sd_busy_i,
    input  logic        sdcmd_i,
    output logic        done_o,
    output cmd_result_t result_o,
    output logic        sdclk_en_o,
    output logic        sdcmd_o,
    output logic        sdcmd_oen_o
);

    logic         cmd_start;
    cmd_desc_t    cmd_desc;
    logic         clr_stat;
    logic         eot;
    logic [127:0] rsp_data;
    status_t      status;

    sdio_cmd_regs sdio_cmd_regs_inst
    (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .cmd_wr_i    (cmd_wr_i),
        .cmd_desc_i  (cmd_desc_i),
        .clr_i       (clr_i),
        .eot_i       (eot),
        .rsp_i       (rsp_data),
        .status_i    (status),
        .cmd_start_o (cmd_start),
        .cmd_desc_o  (cmd_desc),
        .clr_stat_o  (clr_stat),
        .done_o      (done_o),
        .result_o    (result_o)
    );

    sdio_txrx_cmd sdio_txrx_cmd_inst
    (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .clr_stat_i  (clr_stat),
        .cmd_start_i (cmd_start),
        .cmd_desc_i  (cmd_desc),
        .busy_i      (sd_busy_i),
        .sdcmd_i     (sdcmd_i),
        .rsp_data_o  (rsp_data),
        .status_o    (status),
        .eot_o       (eot),
        .sdclk_en_o  (sdclk_en_o),
        .sdcmd_o     (sdcmd_o),
        .sdcmd_oen_o (sdcmd_oen_o)
    );

endmodule

// ==== source/sdio_cmd_regs.sv ====
`timescale 1ns/1ns
// Command front end
// accepts descriptor strobes, refuses them while a command runs,
// and captures response and status when the engine finishes

module sdio_cmd_regs import sdio_pkg::*;
(
    input  logic         clk_i,
    input  logic         rstn_i,
    input  logic         cmd_wr_i,
    input  cmd_desc_t    cmd_desc_i,
    input  logic         clr_i,
    input  logic         eot_i,
    input  logic [127:0] rsp_i,
    input  status_t      status_i,
    output logic         cmd_start_o,
    output cmd_desc_t    cmd_desc_o,
    output logic         clr_stat_o,
    output logic         done_o,
    output cmd_result_t  result_o
);

    logic        accept;
    logic        refuse;
    logic        active_q;
    logic        start_q;
    logic        done_q;
    logic        refused_q;
    cmd_desc_t   desc_q;
    cmd_result_t result_q;
    status_t     merged_status;

    assign accept      = cmd_wr_i & ~active_q;
    assign refuse      = cmd_wr_i & active_q;
    assign cmd_start_o = start_q;
    assign cmd_desc_o  = desc_q;
    assign clr_stat_o  = clr_i;
    assign done_o      = done_q;
    assign result_o    = result_q;

    // a strobe refused in the eot cycle still counts
    always_comb
    begin
        merged_status             = status_i;
        merged_status.cmd_refused = refused_q | refuse;
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            active_q  <= 1'b0;
            start_q   <= 1'b0;
            done_q    <= 1'b0;
            refused_q <= 1'b0;
            result_q  <= '0;
        end
        else if (clr_i)
        begin
            active_q  <= 1'b0;
            start_q   <= 1'b0;
            done_q    <= 1'b0;
            refused_q <= 1'b0;
            result_q  <= '0;
        end
        else
        begin
            start_q <= accept;  // engine starts one cycle later
            done_q  <= eot_i;
            if (accept)
            begin
                active_q        <= 1'b1;
                refused_q       <= 1'b0;
                result_q.status <= '0;
            end
            else if (eot_i)
            begin
                active_q  <= 1'b0;
                refused_q <= 1'b0;
                result_q  <= {rsp_i, merged_status};
            end
            else if (refuse)
            begin
                refused_q <= 1'b1;
            end
        end
    end

    // descriptor held for the whole command
    always_ff @(posedge clk_i)
    begin
        if (accept)
            desc_q <= cmd_desc_i;
    end

endmodule

// ==== source/sdio_txrx_cmd.sv ====
`timescale 1ns/1ns
// SD CMD line engine
// sends the 48-bit command frame, receives a 48 or 136-bit response,
// optionally waits on card busy, then closes with a fixed wait and eot

module sdio_txrx_cmd import sdio_pkg::*;
(
    input  logic         clk_i,
    input  logic         rstn_i,
    input  logic         clr_stat_i,
    input  logic         cmd_start_i,
    input  cmd_desc_t    cmd_desc_i,
    input  logic         busy_i,
    input  logic         sdcmd_i,
    output logic [127:0] rsp_data_o,
    output status_t      status_o,
    output logic         eot_o,
    output logic         sdclk_en_o,
    output logic         sdcmd_o,
    output logic         sdcmd_oen_o
);

    cmd_state_e   state_q;
    cmd_state_e   state_d;
    logic         start_cmd;
    logic [7:0]   cnt_q;
    logic [7:0]   cnt_target;
    logic         cnt_load;
    logic         cnt_done;
    logic         to_wait;
    logic [37:0]  tx_sr_q;
    logic [135:0] rx_sr_q;
    logic         tx_shift;
    logic         rx_shift;
    status_t      status_q;
    logic         set_rsp_timeout;
    logic         set_wrong_dir;
    logic         set_busy_timeout;
    logic         eot;
    logic         cmd_d;
    logic         oen_d;
    logic         cmd_q;
    logic         oen_q;
    logic         crc_sample;
    logic         crc_shift;
    logic         crc_clr;
    logic         crc_serial;
    logic         rsp_en;
    logic         rsp_skip;
    logic         rsp_bsy;
    logic [7:0]   rsp_len;

    assign start_cmd   = (state_q == ST_IDLE) && cmd_start_i;
    assign cnt_done    = (cnt_q == 8'd0);
    assign rsp_data_o  = rx_sr_q[127:0];  // last 128 bits received
    assign status_o    = status_q;
    assign eot_o       = eot;
    assign sdclk_en_o  = (state_q != ST_IDLE);
    assign sdcmd_o     = cmd_q;
    assign sdcmd_oen_o = oen_q;

    sdio_crc7 crc7_inst
    (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .data_i        (cmd_d),
        .sample_i      (crc_sample),
        .shift_i       (crc_shift),
        .clr_i         (crc_clr),
        .crc7_o        (),
        .crc7_serial_o (crc_serial)
    );

    ////////////////////////////////////////
    // response type decode
    ////////////////////////////////////////
    always_comb
    begin
        rsp_en   = 1'b0;
        rsp_skip = 1'b0;
        rsp_len  = 8'(RSP48_BITS - 1);
        case (cmd_desc_i.rsp_type)
            RSP_48_CRC, RSP_48_BSY:
            begin
                rsp_en   = 1'b1;
                rsp_skip = 1'b1;  // crc and end bit follow
            end
            RSP_48_NOCRC:
            begin
                rsp_en = 1'b1;
            end
            RSP_136:
            begin
                rsp_en  = 1'b1;
                rsp_len = 8'(RSP136_BITS - 1);
            end
            default:
            begin
                rsp_en = 1'b0;
            end
        endcase
        rsp_bsy = (cmd_desc_i.rsp_type == RSP_48_BSY);
    end

    ////////////////////////////////////////
    // line FSM
    ////////////////////////////////////////
    always_comb
    begin
        state_d          = state_q;
        cmd_d            = 1'b1;  // line idles high
        oen_d            = 1'b1;  // released
        tx_shift         = 1'b0;
        rx_shift         = 1'b0;
        crc_sample       = 1'b0;
        crc_shift        = 1'b0;
        crc_clr          = 1'b0;
        cnt_load         = 1'b0;
        cnt_target       = 8'd0;
        to_wait          = 1'b0;
        set_rsp_timeout  = 1'b0;
        set_wrong_dir    = 1'b0;
        set_busy_timeout = 1'b0;
        eot              = 1'b0;
        case (state_q)
            ST_IDLE:
            begin
                if (cmd_start_i)
                    state_d = ST_TX_START;
            end
            ST_TX_START:
            begin
                cmd_d   = 1'b0;  // start bit
                oen_d   = 1'b0;
                crc_clr = 1'b1;
                state_d = ST_TX_DIR;
            end
            ST_TX_DIR:
            begin
                oen_d      = 1'b0;  // direction bit is the idle 1
                crc_sample = 1'b1;
                cnt_load   = 1'b1;
                cnt_target = 8'(CMD_SHIFT_BITS - 1);
                state_d    = ST_TX_SHIFT;
            end
            ST_TX_SHIFT:
            begin
                cmd_d      = tx_sr_q[37];
                oen_d      = 1'b0;
                tx_shift   = 1'b1;
                crc_sample = 1'b1;
                if (cnt_done)
                begin
                    cnt_load   = 1'b1;
                    cnt_target = 8'(CRC_BITS - 1);
                    state_d    = ST_TX_CRC;
                end
            end
            ST_TX_CRC:
            begin
                cmd_d     = crc_serial;
                oen_d     = 1'b0;
                crc_shift = 1'b1;
                if (cnt_done)
                    state_d = ST_TX_STOP;
            end
            ST_TX_STOP:
            begin
                oen_d = 1'b0;  // stop bit
                if (rsp_en)
                begin
                    cnt_load   = 1'b1;
                    cnt_target = 8'(RSP_START_WAIT - 1);
                    state_d    = ST_RX_START;
                end
                else
                begin
                    to_wait = 1'b1;
                end
            end
            ST_RX_START:
            begin
                if (!sdcmd_i)
                begin
                    state_d = ST_RX_DIR;
                end
                else if (cnt_done)
                begin
                    set_rsp_timeout = 1'b1;
                    to_wait         = 1'b1;
                end
            end
            ST_RX_DIR:
            begin
                if (!sdcmd_i)
                begin
                    cnt_load   = 1'b1;
                    cnt_target = rsp_len;
                    state_d    = ST_RX_SHIFT;
                end
                else
                begin
                    set_wrong_dir = 1'b1;
                    to_wait       = 1'b1;
                end
            end
            ST_RX_SHIFT:
            begin
                rx_shift = 1'b1;
                if (cnt_done && rsp_skip)
                begin
                    cnt_load   = 1'b1;
                    cnt_target = 8'(CRC_BITS);  // 7 crc bits + end bit
                    state_d    = ST_RX_CRC;
                end
                else if (cnt_done)
                begin
                    to_wait = 1'b1;
                end
            end
            ST_RX_CRC:
            begin
                if (cnt_done && rsp_bsy)
                begin
                    cnt_load   = 1'b1;
                    cnt_target = 8'(BUSY_WAIT - 1);
                    state_d    = ST_WAIT_BUSY;
                end
                else if (cnt_done)
                begin
                    to_wait = 1'b1;
                end
            end
            ST_WAIT_BUSY:
            begin
                if (!busy_i)
                begin
                    to_wait = 1'b1;
                end
                else if (cnt_done)
                begin
                    set_busy_timeout = 1'b1;
                    to_wait          = 1'b1;
                end
            end
            ST_WAIT:
            begin
                if (cnt_done)
                begin
                    eot     = 1'b1;
                    state_d = ST_IDLE;
                end
            end
            default:
            begin
                state_d = ST_IDLE;
            end
        endcase

        // every ending funnels through the closing wait
        if (to_wait)
        begin
            cnt_load   = 1'b1;
            cnt_target = 8'(END_WAIT - 1);
            state_d    = ST_WAIT;
        end
    end

    ////////////////////////////////////////
    // shared down-counter
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            cnt_q <= 8'd0;
        else if (clr_stat_i)
            cnt_q <= 8'd0;
        else if (cnt_load)
            cnt_q <= cnt_target;
        else if (!cnt_done)
            cnt_q <= cnt_q - 8'd1;
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            state_q  <= ST_IDLE;
            status_q <= '0;
        end
        else if (clr_stat_i)
        begin
            state_q  <= ST_IDLE;
            status_q <= '0;
        end
        else
        begin
            state_q <= state_d;
            if (start_cmd)
            begin
                status_q <= '0;  // fresh status per command
            end
            else
            begin
                if (set_rsp_timeout)
                    status_q.rsp_timeout <= 1'b1;
                if (set_wrong_dir)
                    status_q.wrong_dir <= 1'b1;
                if (set_busy_timeout)
                    status_q.busy_timeout <= 1'b1;
            end
        end
    end

    // shift registers for the frame and the response
    always_ff @(posedge clk_i)
    begin
        if (start_cmd)
        begin
            tx_sr_q <= {cmd_desc_i.opcode, cmd_desc_i.arg};
            rx_sr_q <= '0;
        end
        else
        begin
            if (tx_shift)
                tx_sr_q <= {tx_sr_q[36:0], 1'b0};
            if (rx_shift)
                rx_sr_q <= {rx_sr_q[134:0], sdcmd_i};
        end
    end

    // pad signals change on the falling edge
    always_ff @(negedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            cmd_q <= 1'b1;
            oen_q <= 1'b1;
        end
        else
        begin
            cmd_q <= cmd_d;
            oen_q <= oen_d;
        end
    end

endmodule

// ==== source/sdio_crc7.sv ====
`timescale 1ns/1ns
// Serial CRC7 for the SD CMD line, polynomial x^7 + x^3 + 1
// folds one bit per sample and shifts the result out msb first

module sdio_crc7
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       data_i,
    input  logic       sample_i,
    input  logic       shift_i,
    input  logic       clr_i,
    output logic [6:0] crc7_o,
    output logic       crc7_serial_o
);

    logic [6:0] crc_q;
    logic       feedback;

    assign feedback      = data_i ^ crc_q[6];
    assign crc7_o        = crc_q;
    assign crc7_serial_o = crc_q[6];  // next bit to send

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            crc_q <= '0;
        end
        else if (clr_i)
        begin
            crc_q <= '0;
        end
        else if (shift_i)
        begin
            crc_q <= {crc_q[5:0], 1'b0};  // emit msb
        end
        else if (sample_i)
        begin
            crc_q <= {crc_q[5:0], 1'b0} ^ {3'b000, feedback, 2'b00, feedback};
        end
    end

endmodule

// ==== source/sdio_pkg.sv ====
// SD host command path shared definitions
// response types, status flag layout, descriptor, result and engine states

package sdio_pkg;

    ////////////////////////////////////////
    // frame and timing lengths
    ////////////////////////////////////////
    localparam int CMD_SHIFT_BITS = 38;   // index + argument
    localparam int CRC_BITS       = 7;
    localparam int RSP_START_WAIT = 38;   // cycles to see the response start bit
    localparam int RSP48_BITS     = 38;   // bits after the direction bit
    localparam int RSP136_BITS    = 134;
    localparam int BUSY_WAIT      = 256;  // busy timeout in cycles
    localparam int END_WAIT       = 8;    // closing wait before eot

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////
    typedef enum logic [2:0] {
        RSP_NONE     = 3'd0,
        RSP_48_CRC   = 3'd1,
        RSP_48_NOCRC = 3'd2,
        RSP_136      = 3'd3,
        RSP_48_BSY   = 3'd4
    } rsp_type_e;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [31:0] arg;
        rsp_type_e   rsp_type;
    } cmd_desc_t;

    // sticky flags, bit 0 is rsp_timeout
    typedef struct packed {
        logic [1:0] reserved;
        logic       cmd_refused;
        logic       busy_timeout;
        logic       wrong_dir;
        logic       rsp_timeout;
    } status_t;

    typedef struct packed {
        logic [127:0] rsp;
        status_t      status;
    } cmd_result_t;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_TX_START,
        ST_TX_DIR,
        ST_TX_SHIFT,
        ST_TX_CRC,
        ST_TX_STOP,
        ST_RX_START,
        ST_RX_DIR,
        ST_RX_SHIFT,
        ST_RX_CRC,
        ST_WAIT_BUSY,
        ST_WAIT
    } cmd_state_e;

endpackage
